//--- include/burst_defs.svh
// geometry and timing constants of the burst memory subsystem
// included by every RTL block that sizes ports or counters from them
`ifndef BURST_DEFS_SVH
`define BURST_DEFS_SVH

// memory geometry
`define ADDR_W 4         // word address, 16 words
`define DATA_W 64        // one memory data word

// burst shape
`define BURST_LEN 4      // words per read or write burst

// index of a word inside a line buffer, clog2 of BURST_LEN
`define IDX_W 2

// emulated controller delays, in clock cycles
// calibration runs after reset before the first command is accepted
`define INIT_CYCLES 10

// cycles between the read command and the first valid word
`define READ_DELAY 6

`endif

//--- hw/burst_ram_pkg.sv
// types of the burst RAM command bus and its controller FSM
// imported by the RAM model, the arbiter and the top level
package burst_ram_pkg;

  // command driven together with cmd_en
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } ram_cmd_t;

  // one-hot controller states
  typedef enum logic [4:0] {
    RAM_INITIATE    = 5'b00001,  // calibration after reset
    RAM_IDLE        = 5'b00010,
    RAM_READ_DELAY  = 5'b00100,
    RAM_READ_BURST  = 5'b01000,
    RAM_WRITE_BURST = 5'b10000
  } ram_state_t;

endpackage

//--- hw/client_pkg.sv
// types shared by the RAM clients and the arbiter
package client_pkg;

  // names a client on the arbiter side
  typedef enum logic {
    CLIENT_LOADER = 1'b0,
    CLIENT_STORER = 1'b1
  } client_id_t;

  // sequencing of one transfer, same for loader and storer
  typedef enum logic [1:0] {
    CL_IDLE     = 2'd0,
    CL_REQUEST  = 2'd1,  // request held until granted
    CL_TRANSFER = 2'd2
  } client_state_t;

endpackage

//--- hw/burst_ram.sv
// behavioural model of the external burst memory controller
// calibrates after reset, then serves one read or write burst at a time
`timescale 1ns/100ps
`include "burst_defs.svh"

module burst_ram import burst_ram_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  ram_cmd_t           cmd,
  input  logic               cmd_en,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] wr_data,
  output logic [`DATA_W-1:0] rd_data,
  output logic               rd_valid,
  output logic               busy,
  output logic               init_calib
);

  localparam int DEPTH = 1 << `ADDR_W;
  localparam logic [`IDX_W-1:0] LAST_BEAT = `IDX_W'(`BURST_LEN - 1);

  logic [`DATA_W-1:0] mem [DEPTH];

  ram_state_t state;
  logic [$clog2(`INIT_CYCLES+1)-1:0] init_cnt;  // counts up to INIT_CYCLES
  logic [$clog2(`READ_DELAY)-1:0]    delay_cnt;
  logic [`IDX_W-1:0]                 beat_cnt;
  logic [`ADDR_W-1:0]                addr_cnt;  // wraps modulo DEPTH

  logic               mem_we;
  logic [`ADDR_W-1:0] mem_waddr;
  logic               rd_load;

  // first write word lands in the command cycle, the rest follow addr_cnt
  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = addr;
    if (state == RAM_IDLE && cmd_en && cmd == CMD_WRITE) begin
      mem_we = 1'b1;
    end else if (state == RAM_WRITE_BURST && beat_cnt != LAST_BEAT) begin
      mem_we    = 1'b1;
      mem_waddr = addr_cnt;
    end
  end

  // fetch the next read word at the end of the delay and on every beat but the last
  assign rd_load = (state == RAM_READ_DELAY && delay_cnt == ($bits(delay_cnt))'(`READ_DELAY - 1))
                || (state == RAM_READ_BURST && beat_cnt != LAST_BEAT);

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= wr_data;
    end
    if (rd_load) begin
      rd_data <= mem[addr_cnt];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RAM_INITIATE;
      busy       <= 1'b1;  // busy until calibrated
      init_calib <= 1'b0;
      rd_valid   <= 1'b0;
      init_cnt   <= '0;
      delay_cnt  <= '0;
      beat_cnt   <= '0;
      addr_cnt   <= '0;
    end else begin
      unique case (state)
        RAM_INITIATE: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == ($bits(init_cnt))'(`INIT_CYCLES)) begin
            busy       <= 1'b0;
            init_calib <= 1'b1;
            state      <= RAM_IDLE;
          end
        end
        RAM_IDLE: begin
          if (cmd_en) begin
            busy     <= 1'b1;
            beat_cnt <= '0;
            if (cmd == CMD_READ) begin
              delay_cnt <= '0;
              addr_cnt  <= addr;
              state     <= RAM_READ_DELAY;
            end else begin
              addr_cnt <= addr + 1'b1;  // word 0 already written
              state    <= RAM_WRITE_BURST;
            end
          end
        end
        RAM_READ_DELAY: begin
          delay_cnt <= delay_cnt + 1'b1;
          if (rd_load) begin
            rd_valid <= 1'b1;
            addr_cnt <= addr_cnt + 1'b1;
            state    <= RAM_READ_BURST;
          end
        end
        RAM_READ_BURST: begin
          beat_cnt <= beat_cnt + 1'b1;
          addr_cnt <= addr_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) begin
            rd_valid <= 1'b0;
            busy     <= 1'b0;
            state    <= RAM_IDLE;
          end
        end
        RAM_WRITE_BURST: begin
          beat_cnt <= beat_cnt + 1'b1;
          addr_cnt <= addr_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) begin
            busy  <= 1'b0;  // one cycle after the last word
            state <= RAM_IDLE;
          end
        end
        default: begin
          busy  <= 1'b0;
          state <= RAM_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/burst_arbiter.sv
// round-robin arbiter between the line loader and the line storer
// grants the RAM for one whole burst and steers data to the owner only
`timescale 1ns/100ps
`include "burst_defs.svh"

module burst_arbiter import burst_ram_pkg::*, client_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ld_req,
  input  logic [`ADDR_W-1:0] ld_addr,
  input  logic               st_req,
  input  logic [`ADDR_W-1:0] st_addr,
  input  logic [`DATA_W-1:0] st_wr_data,
  input  logic [`DATA_W-1:0] ram_rd_data,
  input  logic               ram_rd_valid,
  input  logic               ram_busy,
  input  logic               init_calib,
  output logic               ld_gnt,
  output logic               st_gnt,
  output logic [`DATA_W-1:0] ld_rd_data,
  output logic               ld_rd_valid,
  output ram_cmd_t           ram_cmd,
  output logic               ram_cmd_en,
  output logic [`ADDR_W-1:0] ram_addr,
  output logic [`DATA_W-1:0] ram_wr_data
);

  logic       in_flight;  // from cmd_en until busy has risen and fallen
  logic       busy_seen;
  client_id_t prio;       // wins when both clients request
  client_id_t owner;
  client_id_t winner;
  logic       ram_free;
  logic       rd_path;
  logic       wr_path;

  assign ram_free = init_calib && !ram_busy && !in_flight;

  always_comb begin
    if (ld_req && st_req) begin
      winner = prio;
    end else if (st_req) begin
      winner = CLIENT_STORER;
    end else begin
      winner = CLIENT_LOADER;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight  <= 1'b0;
      busy_seen  <= 1'b0;
      prio       <= CLIENT_LOADER;
      owner      <= CLIENT_LOADER;
      ram_cmd_en <= 1'b0;
      ld_gnt     <= 1'b0;
      st_gnt     <= 1'b0;
    end else begin
      ram_cmd_en <= 1'b0;  // grant and command are single-cycle pulses
      ld_gnt     <= 1'b0;
      st_gnt     <= 1'b0;
      if (ram_free && (ld_req || st_req)) begin
        ram_cmd_en <= 1'b1;
        ld_gnt     <= (winner == CLIENT_LOADER);
        st_gnt     <= (winner == CLIENT_STORER);
        owner      <= winner;
        prio       <= (winner == CLIENT_LOADER) ? CLIENT_STORER : CLIENT_LOADER;
        in_flight  <= 1'b1;
        busy_seen  <= 1'b0;
      end else if (in_flight) begin
        if (ram_busy) begin
          busy_seen <= 1'b1;
        end else if (busy_seen) begin
          in_flight <= 1'b0;  // burst finished, RAM idle again
          busy_seen <= 1'b0;
        end
      end
    end
  end

  // command and address follow the owner latched with the grant
  assign ram_cmd  = (owner == CLIENT_STORER) ? CMD_WRITE : CMD_READ;
  assign ram_addr = (owner == CLIENT_STORER) ? st_addr : ld_addr;

  assign wr_path     = in_flight && (owner == CLIENT_STORER);
  assign rd_path     = in_flight && (owner == CLIENT_LOADER);
  assign ram_wr_data = wr_path ? st_wr_data : '0;
  assign ld_rd_data  = rd_path ? ram_rd_data : '0;
  assign ld_rd_valid = rd_path && ram_rd_valid;

endmodule

//--- hw/line_loader.sv
// read client: fetches one burst into a line buffer
// the host pulses load_start and reads words by index after ld_done
`timescale 1ns/100ps
`include "burst_defs.svh"

module line_loader import client_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_start,
  input  logic [`ADDR_W-1:0] load_addr,
  input  logic [`IDX_W-1:0]  rd_idx,
  input  logic               gnt,
  input  logic [`DATA_W-1:0] rd_data,
  input  logic               rd_valid,
  output logic [`DATA_W-1:0] rd_word,
  output logic               load_busy,
  output logic               ld_done,
  output logic               req,
  output logic [`ADDR_W-1:0] req_addr
);

  localparam logic [`IDX_W-1:0] LAST_IDX = `IDX_W'(`BURST_LEN - 1);

  client_state_t      state;
  logic [`DATA_W-1:0] line_buf [`BURST_LEN];
  logic [`IDX_W-1:0]  cap_idx;  // next slot to fill

  always_ff @(posedge clk) begin
    if (state == CL_IDLE && load_start) begin
      req_addr <= load_addr;
    end
    if (state == CL_TRANSFER && rd_valid) begin
      line_buf[cap_idx] <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= CL_IDLE;
      cap_idx <= '0;
      ld_done <= 1'b0;
    end else begin
      ld_done <= 1'b0;
      unique case (state)
        CL_IDLE: begin
          if (load_start) begin
            cap_idx <= '0;
            state   <= CL_REQUEST;
          end
        end
        CL_REQUEST: if (gnt) state <= CL_TRANSFER;
        CL_TRANSFER: begin
          if (rd_valid) begin
            cap_idx <= cap_idx + 1'b1;
            if (cap_idx == LAST_IDX) begin
              ld_done <= 1'b1;  // one cycle after the last word
              state   <= CL_IDLE;
            end
          end
        end
        default: state <= CL_IDLE;
      endcase
    end
  end

  assign req       = (state == CL_REQUEST);
  assign load_busy = (state != CL_IDLE);
  assign rd_word   = line_buf[rd_idx];  // host read port

endmodule

//--- hw/line_storer.sv
// write client: the host fills a line buffer, then the line goes out as one burst
// host writes are taken only while idle; st_done marks the RAM going idle
`timescale 1ns/100ps
`include "burst_defs.svh"

module line_storer import client_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  logic [`IDX_W-1:0]  wr_idx,
  input  logic [`DATA_W-1:0] wr_word,
  input  logic               store_start,
  input  logic [`ADDR_W-1:0] store_addr,
  input  logic               gnt,
  input  logic               ram_busy,
  output logic               store_busy,
  output logic               st_done,
  output logic               req,
  output logic [`ADDR_W-1:0] req_addr,
  output logic [`DATA_W-1:0] burst_data
);

  localparam logic [`IDX_W-1:0] LAST_IDX = `IDX_W'(`BURST_LEN - 1);

  client_state_t      state;
  logic [`DATA_W-1:0] line_buf [`BURST_LEN];
  logic [`IDX_W-1:0]  word_idx;   // word on burst_data
  logic               busy_seen;  // RAM has started our burst

  always_ff @(posedge clk) begin
    if (state == CL_IDLE && wr_en) begin
      line_buf[wr_idx] <= wr_word;
    end
    if (state == CL_IDLE && store_start) begin
      req_addr <= store_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= CL_IDLE;
      word_idx  <= '0;
      busy_seen <= 1'b0;
      st_done   <= 1'b0;
    end else begin
      st_done <= 1'b0;
      unique case (state)
        CL_IDLE: begin
          if (store_start) begin
            word_idx  <= '0;
            busy_seen <= 1'b0;
            state     <= CL_REQUEST;
          end
        end
        CL_REQUEST: begin
          if (gnt) begin
            word_idx <= word_idx + 1'b1;  // word 0 went out with the grant
            state    <= CL_TRANSFER;
          end
        end
        CL_TRANSFER: begin
          if (word_idx != LAST_IDX) word_idx <= word_idx + 1'b1;
          if (ram_busy) begin
            busy_seen <= 1'b1;
          end else if (busy_seen) begin
            st_done <= 1'b1;
            state   <= CL_IDLE;
          end
        end
        default: state <= CL_IDLE;
      endcase
    end
  end

  assign req        = (state == CL_REQUEST);
  assign store_busy = (state != CL_IDLE);
  assign burst_data = line_buf[word_idx];

endmodule

//--- hw/burst_subsys_top.sv
// burst memory subsystem: mock RAM shared by a line loader and a line storer
// mem_ready reports RAM calibration; host ports go straight to the clients
`timescale 1ns/100ps
`include "burst_defs.svh"

module burst_subsys_top import burst_ram_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_start,
  input  logic [`ADDR_W-1:0] load_addr,
  input  logic [`IDX_W-1:0]  rd_idx,
  output logic [`DATA_W-1:0] rd_word,
  output logic               load_busy,
  output logic               ld_done,
  input  logic               wr_en,
  input  logic [`IDX_W-1:0]  wr_idx,
  input  logic [`DATA_W-1:0] wr_word,
  input  logic               store_start,
  input  logic [`ADDR_W-1:0] store_addr,
  output logic               store_busy,
  output logic               st_done,
  output logic               mem_ready
);

  // client side of the arbiter
  logic               ld_req, ld_gnt, ld_rd_valid;
  logic [`ADDR_W-1:0] ld_addr;
  logic [`DATA_W-1:0] ld_rd_data;
  logic               st_req, st_gnt;
  logic [`ADDR_W-1:0] st_addr;
  logic [`DATA_W-1:0] st_wr_data;

  // RAM bus
  ram_cmd_t           ram_cmd;
  logic               ram_cmd_en, ram_rd_valid, ram_busy;
  logic [`ADDR_W-1:0] ram_addr;
  logic [`DATA_W-1:0] ram_wr_data, ram_rd_data;

  burst_ram u_ram (
    .clk, .rst_n, .cmd(ram_cmd), .cmd_en(ram_cmd_en), .addr(ram_addr),
    .wr_data(ram_wr_data), .rd_data(ram_rd_data), .rd_valid(ram_rd_valid),
    .busy(ram_busy), .init_calib(mem_ready)
  );

  burst_arbiter u_arb (
    .clk, .rst_n, .ld_req, .ld_addr, .st_req, .st_addr, .st_wr_data,
    .ram_rd_data, .ram_rd_valid, .ram_busy, .init_calib(mem_ready),
    .ld_gnt, .st_gnt, .ld_rd_data, .ld_rd_valid,
    .ram_cmd, .ram_cmd_en, .ram_addr, .ram_wr_data
  );

  line_loader u_loader (
    .clk, .rst_n, .load_start, .load_addr, .rd_idx, .gnt(ld_gnt),
    .rd_data(ld_rd_data), .rd_valid(ld_rd_valid), .rd_word, .load_busy,
    .ld_done, .req(ld_req), .req_addr(ld_addr)
  );

  line_storer u_storer (
    .clk, .rst_n, .wr_en, .wr_idx, .wr_word, .store_start, .store_addr,
    .gnt(st_gnt), .ram_busy, .store_busy, .st_done, .req(st_req),
    .req_addr(st_addr), .burst_data(st_wr_data)
  );

endmodule

//--- verif/burst_subsys_assert.sv
// checks on the RAM command bus, bound into the arbiter
// fails counts the failed assertions
`timescale 1ns/100ps
`include "burst_defs.svh"

module burst_subsys_assert (
  input logic clk,
  input logic rst_n,
  input logic ram_cmd_en,
  input logic ram_busy,
  input logic init_calib,
  input logic ld_gnt,
  input logic st_gnt,
  input logic ram_rd_valid
);

  int fails = 0;

  // commands only reach a calibrated, idle RAM
  cmd_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    ram_cmd_en |-> !ram_busy && init_calib)
    else begin
      fails++;
      $error("cmd_en while the RAM is busy or not calibrated");
    end

  one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(ld_gnt && st_gnt))
    else begin
      fails++;
      $error("both clients granted in one cycle");
    end

  // a read burst is exactly BURST_LEN words long
  read_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ram_rd_valid) |-> ram_rd_valid [*`BURST_LEN] ##1 !ram_rd_valid)
    else begin
      fails++;
      $error("read burst length differs from BURST_LEN");
    end

endmodule

bind burst_arbiter burst_subsys_assert u_assert (
  .clk, .rst_n, .ram_cmd_en, .ram_busy, .init_calib, .ld_gnt, .st_gnt, .ram_rd_valid
);

//--- verif/burst_subsys_tb.sv
// directed testbench for the burst memory subsystem
// covers calibration, store and load, address wrap, contention and back-to-back stores
`timescale 1ns/100ps
`include "burst_defs.svh"

module burst_subsys_tb;

  localparam int TIMEOUT = 2000;  // full sequence runs in about 400 cycles

  logic               clk;
  logic               rst_n;
  logic               load_start;
  logic               store_start;
  logic               wr_en;
  logic [`ADDR_W-1:0] load_addr;
  logic [`ADDR_W-1:0] store_addr;
  logic [`IDX_W-1:0]  rd_idx;
  logic [`IDX_W-1:0]  wr_idx;
  logic [`DATA_W-1:0] wr_word;
  logic [`DATA_W-1:0] rd_word;
  logic               load_busy, ld_done, store_busy, st_done, mem_ready;

  logic [`DATA_W-1:0] ref_mem [1 << `ADDR_W];  // expected RAM contents
  logic [`DATA_W-1:0] line [`BURST_LEN];       // line for the next store
  logic [31:0]        rng = 32'h3a43_45a1;
  int errors = 0;
  int cycles = 0;
  int ld_starts = 0;
  int st_starts = 0;
  int ld_dones = 0;
  int st_dones = 0;

  burst_subsys_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // done pulse counters and the run limit
  always @(negedge clk) begin
    cycles++;
    if (ld_done) ld_dones++;
    if (st_done) st_dones++;
    if (cycles == TIMEOUT) begin
      $display("run stopped after %0d cycles, a done pulse never arrived", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic new_line();
    for (int i = 0; i < `BURST_LEN; i++) begin
      rng = xorshift(rng);
      line[i][63:32] = rng;
      rng = xorshift(rng);
      line[i][31:0] = rng;
    end
  endtask

  task automatic check(input string name, input logic [`DATA_W-1:0] exp, act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic note_fail(input string msg);
    errors++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  task automatic fill_storer();  // host writes the whole line
    for (int i = 0; i < `BURST_LEN; i++) begin
      @(negedge clk);
      wr_en   = 1'b1;
      wr_idx  = `IDX_W'(i);
      wr_word = line[i];
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic start_store(input logic [`ADDR_W-1:0] addr);
    @(negedge clk);
    store_start = 1'b1;
    store_addr  = addr;
    st_starts++;
    @(negedge clk);
    store_start = 1'b0;
  endtask

  task automatic start_load(input logic [`ADDR_W-1:0] addr);
    @(negedge clk);
    load_start = 1'b1;
    load_addr  = addr;
    ld_starts++;
    @(negedge clk);
    load_start = 1'b0;
  endtask

  task automatic start_both(input logic [`ADDR_W-1:0] addr);
    @(negedge clk);
    load_start  = 1'b1;
    load_addr   = addr;
    store_start = 1'b1;
    store_addr  = addr;
    ld_starts++;
    st_starts++;
    @(negedge clk);
    load_start  = 1'b0;
    store_start = 1'b0;
  endtask

  task automatic wait_done(input bit store);
    do begin
      @(negedge clk);
    end while (!(store ? st_done : ld_done));
  endtask

  task automatic wait_both(output int ld_at, output int st_at);
    int n;
    n = 0;
    ld_at = 0;
    st_at = 0;
    while (ld_at == 0 || st_at == 0) begin
      @(negedge clk);
      n++;
      if (ld_done) ld_at = n;
      if (st_done) st_at = n;
    end
  endtask

  task automatic commit(input logic [`ADDR_W-1:0] addr);  // burst wraps at 16 words
    for (int i = 0; i < `BURST_LEN; i++) ref_mem[`ADDR_W'(addr + i)] = line[i];
  endtask

  task automatic store_line(input logic [`ADDR_W-1:0] addr);
    fill_storer();
    start_store(addr);
    wait_done(1'b1);
    commit(addr);
  endtask

  task automatic load_line(input logic [`ADDR_W-1:0] addr);
    start_load(addr);
    wait_done(1'b0);
  endtask

  task automatic check_loaded(input logic [`ADDR_W-1:0] addr, input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      rd_idx = `IDX_W'(i);
      @(negedge clk);
      check($sformatf("rd_word[%0d]", i), ref_mem[`ADDR_W'(addr + i)], rd_word);
    end
  endtask

  task automatic calibration_check();
    repeat (16) @(negedge clk);
    check("mem_ready", 1'b0, mem_ready);
    rst_n = 1'b1;
    for (int k = 1; k <= `INIT_CYCLES + 1; k++) begin
      @(negedge clk);
      check("mem_ready", (k == `INIT_CYCLES + 1), mem_ready);
      if (load_busy || store_busy) note_fail("a client reports busy before calibration");
    end
  endtask

  task automatic store_then_load();
    new_line();
    store_line(4);
    load_line(4);
    check_loaded(4, `BURST_LEN);
  endtask

  task automatic address_wrap();
    new_line();
    store_line(14);
    load_line(0);
    check_loaded(0, 2);  // words 2 and 3 of the line at 14
    load_line(14);
    check_loaded(14, `BURST_LEN);
  endtask

  task automatic contention_order();
    int ld_at, st_at;
    new_line();
    store_line(8);  // old line at 8 with the pointer back at the loader
    new_line();
    fill_storer();
    start_both(8);
    wait_both(ld_at, st_at);
    if (ld_at >= st_at) note_fail("loader did not finish first while it had priority");
    check_loaded(8, `BURST_LEN);  // still the old line
    commit(8);
    load_line(8);
    check_loaded(8, `BURST_LEN);
    new_line();
    fill_storer();
    start_both(8);
    wait_both(ld_at, st_at);
    if (st_at >= ld_at) note_fail("storer did not finish first while it had priority");
    commit(8);
    check_loaded(8, `BURST_LEN);
  endtask

  task automatic back_to_back_stores();
    new_line();
    fill_storer();
    start_store(0);
    repeat (2) @(negedge clk);
    if (!store_busy) note_fail("store_busy low during a store");
    store_start = 1'b1;  // must be ignored
    store_addr  = 12;
    @(negedge clk);
    store_start = 1'b0;
    wait_done(1'b1);
    commit(0);
    new_line();
    store_line(12);
    start_load(0);
    repeat (2) @(negedge clk);
    if (!load_busy) note_fail("load_busy low during a load");
    load_start = 1'b1;  // must be ignored
    load_addr  = 12;
    @(negedge clk);
    load_start = 1'b0;
    wait_done(1'b0);
    check_loaded(0, `BURST_LEN);
    load_line(12);
    check_loaded(12, `BURST_LEN);
  endtask

  initial begin
    rst_n       = 1'b0;
    load_start  = 1'b0;
    load_addr   = '0;
    rd_idx      = '0;
    wr_en       = 1'b0;
    wr_idx      = '0;
    wr_word     = '0;
    store_start = 1'b0;
    store_addr  = '0;
    calibration_check();
    store_then_load();
    address_wrap();
    contention_order();
    back_to_back_stores();
    repeat (20) @(negedge clk);  // room for a stray done pulse
    check("ld_done count", ld_starts, ld_dones);
    check("st_done count", st_starts, st_dones);
    if (uut.u_arb.u_assert.fails != 0) note_fail("assertions on the RAM bus failed");
    $display("%0d errors, %0d loads, %0d stores", errors, ld_starts, st_starts);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hw/burst_ram_pkg.sv
hw/client_pkg.sv
hw/burst_ram.sv
hw/burst_arbiter.sv
hw/line_loader.sv
hw/line_storer.sv
hw/burst_subsys_top.sv
verif/burst_subsys_assert.sv
verif/burst_subsys_tb.sv

//--- Bender.yml
package:
  name: burst_subsys

sources:
  - include_dirs:
      - include
    files:
      - hw/burst_ram_pkg.sv
      - hw/client_pkg.sv
      - hw/burst_ram.sv
      - hw/burst_arbiter.sv
      - hw/line_loader.sv
      - hw/line_storer.sv
      - hw/burst_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/burst_subsys_assert.sv
      - verif/burst_subsys_tb.sv
